// ==== design/mcu_pkg.sv ====
// ***************************************************************************
// bus structs, target enum, memory map, always-on register offsets
// and interrupt vector positions
// ***************************************************************************

package mcu_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;

  // memory banks
  localparam int unsigned NUM_BANKS  = 2;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS);
  localparam int unsigned WORD_LSB   = $clog2(BE_W);
  localparam int unsigned BANK_LSB   = WORD_LSB + BANK_AW;
  localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);

  // memory map
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] RAM_SIZE = ADDR_W'(NUM_BANKS * BANK_WORDS * BE_W);
  localparam logic [ADDR_W-1:0] AO_BASE  = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] AO_SIZE  = 32'h0000_1000;
  localparam int unsigned       AO_OFS_W = $clog2(AO_SIZE);

  // always-on register offsets
  localparam logic [AO_OFS_W-1:0] EXIT_VALID_OFS = 12'h000;
  localparam logic [AO_OFS_W-1:0] EXIT_VALUE_OFS = 12'h004;
  localparam logic [AO_OFS_W-1:0] MSIP_OFS       = 12'h008;
  localparam logic [AO_OFS_W-1:0] FAST_PEND_OFS  = 12'h00C;
  localparam logic [AO_OFS_W-1:0] FAST_EN_OFS    = 12'h010;

  // interrupt vector layout
  localparam int unsigned INTR_W        = 32;
  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int unsigned IRQ_SW_BIT    = 3;
  localparam int unsigned IRQ_EXT_BIT   = 11;
  localparam int unsigned IRQ_FAST_LSB  = 16;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

  typedef enum logic [1:0] {
    TGT_RAM0 = 2'd0,
    TGT_RAM1 = 2'd1,
    TGT_AO   = 2'd2,
    TGT_NONE = 2'd3
  } bus_tgt_e;

endpackage

// ==== design/sys_bus_decoder.sv ====
// ***************************************************************************
// system bus address decoder, one request fanned out to ram banks
// and the always-on block
// ***************************************************************************

`timescale 1ns/1ps

module sys_bus_decoder
  import mcu_pkg::*;
(
  input  obi_req_t                 bus_req_i,
  output obi_req_t [NUM_BANKS-1:0] ram_req_o,
  output obi_req_t                 ao_req_o,
  output bus_tgt_e                 tgt_o
);

  logic [ADDR_W-1:0]     ram_ofs;
  logic [ADDR_W-1:0]     ao_ofs;
  logic [BANK_SEL_W-1:0] bank_idx;
  logic [NUM_BANKS-1:0]  ram_hit;
  logic                  ao_hit;

  // offsets into each window, wrap makes anything below base look out of range
  assign ram_ofs  = bus_req_i.addr - RAM_BASE;
  assign ao_ofs   = bus_req_i.addr - AO_BASE;
  assign bank_idx = ram_ofs[BANK_LSB +: BANK_SEL_W];

  always_comb begin
    ram_hit = '0;
    ao_hit  = 1'b0;
    tgt_o   = TGT_NONE;
    if (ram_ofs < RAM_SIZE) begin
      ram_hit[bank_idx] = 1'b1;
      tgt_o = (bank_idx == '0) ? TGT_RAM0 : TGT_RAM1;
    end else if (ao_ofs < AO_SIZE) begin
      ao_hit = 1'b1;
      tgt_o  = TGT_AO;
    end
  end

  // payload goes everywhere, only the selected target sees req
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      ram_req_o[i]     = bus_req_i;
      ram_req_o[i].req = bus_req_i.req & ram_hit[i];
    end
    ao_req_o     = bus_req_i;
    ao_req_o.req = bus_req_i.req & ao_hit;
  end

endmodule

// ==== design/ram_bank.sv ====
// ***************************************************************************
// single-port ram bank with byte enables, response one cycle after req
// ***************************************************************************

`timescale 1ns/1ps

module ram_bank
  import mcu_pkg::*;
(
  input  logic      clk_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [DATA_W-1:0]  mem [BANK_WORDS];
  logic [BANK_AW-1:0] word_idx;
  logic               rvalid_q;
  logic [DATA_W-1:0]  rdata_q;

  // byte offset bits dropped, bank select bit handled by the decoder
  assign word_idx = req_i.addr[WORD_LSB +: BANK_AW];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rvalid_q <= req_i.req;
    if (req_i.req && !req_i.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  // always ready, never faults
  assign resp_o.gnt    = 1'b1;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

// ==== design/ao_peripheral_regs.sv ====
// ***************************************************************************
// always-on registers: exit value/valid, software interrupt,
// fast interrupt pending and enable
// ***************************************************************************

`timescale 1ns/1ps

module ao_peripheral_regs
  import mcu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  obi_req_t                 req_i,
  output obi_resp_t                resp_o,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] irq_fast_o,
  output logic                     msip_o,
  output logic                     exit_valid_o,
  output logic [DATA_W-1:0]        exit_value_o
);

  logic [AO_OFS_W-1:0]      reg_ofs;
  logic                     wr_en;
  logic                     rd_en;
  logic [DATA_W-1:0]        rd_val;
  logic [NUM_FAST_INTR-1:0] pend_clr;

  logic                     exit_valid_q;
  logic [DATA_W-1:0]        exit_value_q;
  logic                     msip_q;
  logic [NUM_FAST_INTR-1:0] pend_q;
  logic [NUM_FAST_INTR-1:0] en_q;
  logic                     rvalid_q;
  logic [DATA_W-1:0]        rdata_q;

  assign reg_ofs = req_i.addr[AO_OFS_W-1:0];
  assign wr_en   = req_i.req & req_i.we;
  assign rd_en   = req_i.req & ~req_i.we;

  // write one to clear
  assign pend_clr = (wr_en && reg_ofs == FAST_PEND_OFS) ?
                    req_i.wdata[NUM_FAST_INTR-1:0] : '0;

  always_comb begin
    unique case (reg_ofs)
      EXIT_VALID_OFS: rd_val = DATA_W'(exit_valid_q);
      EXIT_VALUE_OFS: rd_val = exit_value_q;
      MSIP_OFS:       rd_val = DATA_W'(msip_q);
      FAST_PEND_OFS:  rd_val = DATA_W'(pend_q);
      FAST_EN_OFS:    rd_val = DATA_W'(en_q);
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      msip_q       <= 1'b0;
      pend_q       <= '0;
      en_q         <= '0;
      rvalid_q     <= 1'b0;
      rdata_q      <= '0;
    end else begin
      rvalid_q <= req_i.req;
      rdata_q  <= rd_en ? rd_val : '0;
      // a source still high overrides the clear
      pend_q   <= (pend_q & ~pend_clr) | fast_intr_i;
      if (wr_en) begin
        unique case (reg_ofs)
          // sticky until reset
          EXIT_VALID_OFS: exit_valid_q <= exit_valid_q | req_i.wdata[0];
          EXIT_VALUE_OFS: exit_value_q <= req_i.wdata;
          MSIP_OFS:       msip_q       <= req_i.wdata[0];
          FAST_EN_OFS:    en_q         <= req_i.wdata[NUM_FAST_INTR-1:0];
          default: ;
        endcase
      end
    end
  end

  assign irq_fast_o   = pend_q & en_q;
  assign msip_o       = msip_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  assign resp_o.gnt    = 1'b1;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

// ==== design/sys_bus_resp_mux.sv ====
// ***************************************************************************
// response steering: remembers the granted target, returns its response
// and builds the error response for unmapped accesses
// ***************************************************************************

`timescale 1ns/1ps

module sys_bus_resp_mux
  import mcu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  obi_req_t                  bus_req_i,
  input  bus_tgt_e                  tgt_i,
  input  obi_resp_t [NUM_BANKS-1:0] ram_resp_i,
  input  obi_resp_t                 ao_resp_i,
  output obi_resp_t                 bus_resp_o
);

  bus_tgt_e  tgt_q;
  logic      valid_q;
  obi_resp_t sel_resp;

  // every target accepts at once, so each req is a grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tgt_q   <= TGT_NONE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        tgt_q <= tgt_i;
      end
    end
  end

  always_comb begin
    unique case (tgt_q)
      TGT_RAM0: sel_resp = ram_resp_i[0];
      TGT_RAM1: sel_resp = ram_resp_i[1];
      TGT_AO:   sel_resp = ao_resp_i;
      // unmapped, answered here
      default: begin
        sel_resp        = '0;
        sel_resp.rvalid = 1'b1;
        sel_resp.err    = 1'b1;
      end
    endcase
  end

  assign bus_resp_o.gnt    = bus_req_i.req;
  assign bus_resp_o.rvalid = valid_q & sel_resp.rvalid;
  assign bus_resp_o.err    = valid_q & sel_resp.err;
  assign bus_resp_o.rdata  = sel_resp.rdata;

endmodule

// ==== design/mini_mcu_top.sv ====
// ***************************************************************************
// mini mcu top: system bus, ram banks, always-on block, interrupt vector
// ***************************************************************************

`timescale 1ns/1ps

module mini_mcu_top
  import mcu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  obi_req_t                 bus_req_i,
  output obi_resp_t                bus_resp_o,
  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  input  logic                     irq_external_i,
  output logic [INTR_W-1:0]        intr_o,
  output logic                     exit_valid_o,
  output logic [DATA_W-1:0]        exit_value_o
);

  obi_req_t  [NUM_BANKS-1:0] ram_req;
  obi_resp_t [NUM_BANKS-1:0] ram_resp;
  obi_req_t                  ao_req;
  obi_resp_t                 ao_resp;
  bus_tgt_e                  tgt;

  logic                      irq_software;
  logic [NUM_FAST_INTR-1:0]  irq_fast;

  sys_bus_decoder i_decoder (
    .bus_req_i (bus_req_i),
    .ram_req_o (ram_req),
    .ao_req_o  (ao_req),
    .tgt_o     (tgt)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    ram_bank i_ram_bank (
      .clk_i  (clk_i),
      .req_i  (ram_req[b]),
      .resp_o (ram_resp[b])
    );
  end

  ao_peripheral_regs i_ao_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (ao_req),
    .resp_o       (ao_resp),
    .fast_intr_i  (fast_intr_i),
    .irq_fast_o   (irq_fast),
    .msip_o       (irq_software),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

  sys_bus_resp_mux i_resp_mux (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bus_req_i  (bus_req_i),
    .tgt_i      (tgt),
    .ram_resp_i (ram_resp),
    .ao_resp_i  (ao_resp),
    .bus_resp_o (bus_resp_o)
  );

  // no timer here, bit 7 stays low
  always_comb begin
    intr_o = '0;
    intr_o[IRQ_SW_BIT]  = irq_software;
    intr_o[IRQ_EXT_BIT] = irq_external_i;
    intr_o[IRQ_FAST_LSB +: NUM_FAST_INTR] = irq_fast;
  end

endmodule

// ==== testbench/mini_mcu_properties.sv ====
// ***************************************************************************
// bus handshake and interrupt vector assertions, bound into mini_mcu_top
// ***************************************************************************

`timescale 1ns/1ps

module mini_mcu_properties
  import mcu_pkg::*;
(
  input logic              clk_i,
  input logic              rst_n_i,
  input obi_req_t          bus_req_i,
  input obi_resp_t         bus_resp_o,
  input logic [INTR_W-1:0] intr_o,
  input logic              exit_valid_o
);

  logic [INTR_W-1:0] used_bits;

  // software, external and fast lines, everything else reserved
  assign used_bits = (INTR_W'(1) << IRQ_SW_BIT) | (INTR_W'(1) << IRQ_EXT_BIT) |
                     (INTR_W'({NUM_FAST_INTR{1'b1}}) << IRQ_FAST_LSB);

  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_resp_o.rvalid |-> $past(bus_req_i.req & bus_resp_o.gnt))
    else $error("rvalid without a grant one cycle earlier");

  grant_gets_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bus_req_i.req & bus_resp_o.gnt) |=> bus_resp_o.rvalid)
    else $error("grant not followed by rvalid");

  gnt_equals_req: assert property (@(posedge clk_i)
    bus_resp_o.gnt == bus_req_i.req)
    else $error("gnt differs from req");

  exit_valid_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_o |=> exit_valid_o)
    else $error("exit_valid_o fell outside reset");

  reserved_intr_zero: assert property (@(posedge clk_i)
    (intr_o & ~used_bits) == '0)
    else $error("reserved bit of intr_o is set");

endmodule

bind mini_mcu_top mini_mcu_properties i_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .bus_req_i    (bus_req_i),
  .bus_resp_o   (bus_resp_o),
  .intr_o       (intr_o),
  .exit_valid_o (exit_valid_o)
);

// ==== testbench/tb_clock_gen.sv ====
// ***************************************************************************
// clock and synchronous reset for the testbench
// ***************************************************************************

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low for 16 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== testbench/tb_mini_mcu.sv ====
// ***************************************************************************
// directed tests for mini_mcu_top: ram banks, unmapped access,
// exit registers, software/external/fast interrupts
// ***************************************************************************

`timescale 1ns/1ps

module tb_mini_mcu
  import mcu_pkg::*;
();

  localparam int TIMEOUT   = 50;
  localparam int NUM_WORDS = 12;
  localparam int RAM_IDX_W = BANK_AW + BANK_SEL_W;

  logic                     clk;
  logic                     rst_n;
  obi_req_t                 bus_req;
  obi_resp_t                bus_resp;
  logic [NUM_FAST_INTR-1:0] fast_intr;
  logic                     irq_ext;
  logic [INTR_W-1:0]        intr;
  logic                     exit_valid;
  logic [DATA_W-1:0]        exit_value;

  obi_resp_t                resp_q[$];
  logic [DATA_W-1:0]        model [NUM_BANKS*BANK_WORDS];
  logic [RAM_IDX_W-1:0]     word_idx [NUM_WORDS];
  integer                   seed;
  int                       errors;
  int                       checks;
  int                       test_errors;
  int                       tests_run;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mini_mcu_top i_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .bus_req_i      (bus_req),
    .bus_resp_o     (bus_resp),
    .fast_intr_i    (fast_intr),
    .irq_external_i (irq_ext),
    .intr_o         (intr),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  // responses collected mid-cycle, consumed in issue order
  always @(negedge clk) begin
    if (rst_n && bus_resp.rvalid) begin
      resp_q.push_back(bus_resp);
    end
  end

  function automatic logic [INTR_W-1:0] fast_vec(input logic [NUM_FAST_INTR-1:0] v);
    fast_vec = INTR_W'(v) << IRQ_FAST_LSB;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic issue_request(input logic we, input logic [BE_W-1:0] be,
                               input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
    obi_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    @(posedge clk);
    bus_req <= r;
  endtask

  task automatic release_bus();
    @(posedge clk);
    bus_req <= '0;
  endtask

  task automatic wait_responses(input int n, output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b1;
    while (resp_q.size() < n && ok) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: only %0d of %0d bus responses arrived", resp_q.size(), n);
        errors++;
        test_errors++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic access(input logic we, input logic [BE_W-1:0] be,
                        input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                        output obi_resp_t rsp);
    bit ok;
    issue_request(we, be, addr, wdata);
    release_bus();
    wait_responses(1, ok);
    if (ok) begin
      rsp = resp_q.pop_front();
    end else begin
      rsp = '0;
    end
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    obi_resp_t rsp;
    access(1'b1, 4'hf, addr, data, rsp);
    check_equal("bus_resp_o.err", 32'(rsp.err), 32'h0);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    obi_resp_t rsp;
    access(1'b0, 4'hf, addr, '0, rsp);
    check_equal("bus_resp_o.err", 32'(rsp.err), 32'h0);
    data = rsp.rdata;
  endtask

  // polls intr_o on falling edges until the masked bits match
  task automatic wait_intr(input logic [31:0] mask, input logic [31:0] exp, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (((intr & mask) !== exp) && cycles <= TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles > TIMEOUT) begin
      $display("timeout: intr_o never showed %s", what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %-12s done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic reset_state_test();
    logic [DATA_W-1:0] data;
    @(negedge clk);
    check_equal("bus_resp_o.rvalid", 32'(bus_resp.rvalid), 32'h0);
    check_equal("exit_valid_o", 32'(exit_valid), 32'h0);
    check_equal("intr_o", intr, 32'h0);
    read_word(AO_BASE + 32'(FAST_EN_OFS), data);
    check_equal("fast_en", data, 32'h0);
    read_word(AO_BASE + 32'(FAST_PEND_OFS), data);
    check_equal("fast_pend", data, 32'h0);
    end_test("reset_state");
  endtask

  task automatic ram_bank_test();
    logic [31:0]       tmp;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    obi_resp_t         rsp;
    bit                ok;
    // full words, back to back, alternating banks
    for (int i = 0; i < NUM_WORDS; i++) begin
      tmp = $random(seed);
      word_idx[i] = {RAM_IDX_W'(i % NUM_BANKS)} << BANK_AW | RAM_IDX_W'(tmp[7:0]);
      tmp = $random(seed);
      model[word_idx[i]] = tmp;
      issue_request(1'b1, 4'hf, RAM_BASE + {21'b0, word_idx[i], 2'b00}, tmp);
    end
    // partial writes merged into the model byte by byte
    for (int i = 0; i < NUM_WORDS; i++) begin
      tmp = $random(seed);
      be = tmp[BE_W-1:0];
      tmp = $random(seed);
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) begin
          model[word_idx[i]][8*b +: 8] = tmp[8*b +: 8];
        end
      end
      issue_request(1'b1, be, RAM_BASE + {21'b0, word_idx[i], 2'b00}, tmp);
    end
    release_bus();
    wait_responses(2 * NUM_WORDS, ok);
    while (resp_q.size() > 0) begin
      rsp = resp_q.pop_front();
      check_equal("bus_resp_o.err", 32'(rsp.err), 32'h0);
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr = RAM_BASE + {21'b0, word_idx[i], 2'b00};
      issue_request(1'b0, 4'hf, addr, '0);
    end
    release_bus();
    wait_responses(NUM_WORDS, ok);
    for (int i = 0; i < NUM_WORDS && resp_q.size() > 0; i++) begin
      rsp = resp_q.pop_front();
      check_equal("bus_resp_o.err", 32'(rsp.err), 32'h0);
      check_equal("bus_resp_o.rdata", rsp.rdata, model[word_idx[i]]);
    end
    end_test("ram_banks");
  endtask

  task automatic unmapped_test();
    obi_resp_t rsp;
    access(1'b0, 4'hf, 32'h1000_0000, '0, rsp);
    check_equal("bus_resp_o.err", 32'(rsp.err), 32'h1);
    check_equal("bus_resp_o.rdata", rsp.rdata, 32'h0);
    access(1'b1, 4'hf, 32'h4000_0010, 32'hdead_beef, rsp);
    check_equal("bus_resp_o.err", 32'(rsp.err), 32'h1);
    check_equal("bus_resp_o.rdata", rsp.rdata, 32'h0);
    end_test("unmapped");
  endtask

  task automatic exit_reg_test();
    logic [DATA_W-1:0] value;
    logic [DATA_W-1:0] data;
    value = $random(seed);
    write_word(AO_BASE + 32'(EXIT_VALUE_OFS), value);
    @(negedge clk);
    check_equal("exit_value_o", exit_value, value);
    read_word(AO_BASE + 32'(EXIT_VALUE_OFS), data);
    check_equal("exit_value", data, value);
    check_equal("exit_valid_o", 32'(exit_valid), 32'h0);
    write_word(AO_BASE + 32'(EXIT_VALID_OFS), 32'h1);
    @(negedge clk);
    check_equal("exit_valid_o", 32'(exit_valid), 32'h1);
    // sticky, a zero write has no effect
    write_word(AO_BASE + 32'(EXIT_VALID_OFS), 32'h0);
    @(negedge clk);
    check_equal("exit_valid_o", 32'(exit_valid), 32'h1);
    read_word(AO_BASE + 32'(EXIT_VALID_OFS), data);
    check_equal("exit_valid", data, 32'h1);
    end_test("exit_regs");
  endtask

  task automatic sw_ext_irq_test();
    logic [DATA_W-1:0] data;
    write_word(AO_BASE + 32'(MSIP_OFS), 32'h1);
    wait_intr(32'h1 << IRQ_SW_BIT, 32'h1 << IRQ_SW_BIT, "the software interrupt");
    check_equal("intr_o", intr, 32'h1 << IRQ_SW_BIT);
    read_word(AO_BASE + 32'(MSIP_OFS), data);
    check_equal("msip", data, 32'h1);
    @(posedge clk);
    irq_ext <= 1'b1;
    wait_intr(32'h1 << IRQ_EXT_BIT, 32'h1 << IRQ_EXT_BIT, "the external interrupt");
    check_equal("intr_o", intr, (32'h1 << IRQ_SW_BIT) | (32'h1 << IRQ_EXT_BIT));
    write_word(AO_BASE + 32'(MSIP_OFS), 32'h0);
    @(posedge clk);
    irq_ext <= 1'b0;
    wait_intr(32'hffff_ffff, 32'h0, "all lines low");
    check_equal("intr_o", intr, 32'h0);
    end_test("sw_ext_irq");
  endtask

  task automatic fast_irq_test();
    logic [31:0]              tmp;
    logic [NUM_FAST_INTR-1:0] pulse;
    logic [NUM_FAST_INTR-1:0] en;
    logic [NUM_FAST_INTR-1:0] clr;
    logic [NUM_FAST_INTR-1:0] low_bit;
    logic [DATA_W-1:0]        data;
    obi_resp_t                rsp;
    bit                       ok;
    tmp = $random(seed);
    pulse = (tmp[NUM_FAST_INTR-1:0] == '0) ? 15'h1 : tmp[NUM_FAST_INTR-1:0];
    low_bit = pulse & (~pulse + 15'd1);
    tmp = $random(seed);
    // at least one pulsed line enabled
    en = tmp[NUM_FAST_INTR-1:0] | low_bit;
    write_word(AO_BASE + 32'(FAST_EN_OFS), 32'(en));
    read_word(AO_BASE + 32'(FAST_EN_OFS), data);
    check_equal("fast_en", data, 32'(en));
    @(posedge clk);
    fast_intr <= pulse;
    @(posedge clk);
    fast_intr <= '0;
    wait_intr(fast_vec('1), fast_vec(pulse & en), "the fast interrupts");
    read_word(AO_BASE + 32'(FAST_PEND_OFS), data);
    check_equal("fast_pend", data, 32'(pulse));
    check_equal("intr_o", intr, fast_vec(pulse & en));
    tmp = $random(seed);
    clr = (tmp[NUM_FAST_INTR-1:0] & pulse) == '0 ? low_bit : tmp[NUM_FAST_INTR-1:0] & pulse;
    write_word(AO_BASE + 32'(FAST_PEND_OFS), 32'(clr));
    read_word(AO_BASE + 32'(FAST_PEND_OFS), data);
    check_equal("fast_pend", data, 32'(pulse & ~clr));
    check_equal("intr_o", intr, fast_vec(pulse & ~clr & en));
    // clear loses against a source high in the same cycle
    issue_request(1'b1, 4'hf, AO_BASE + 32'(FAST_PEND_OFS), 32'h7fff);
    fast_intr <= low_bit;
    release_bus();
    fast_intr <= '0;
    wait_responses(1, ok);
    if (ok) begin
      rsp = resp_q.pop_front();
      check_equal("bus_resp_o.err", 32'(rsp.err), 32'h0);
    end
    read_word(AO_BASE + 32'(FAST_PEND_OFS), data);
    check_equal("fast_pend", data, 32'(low_bit));
    // source low now, so the clear takes effect
    write_word(AO_BASE + 32'(FAST_PEND_OFS), 32'h7fff);
    read_word(AO_BASE + 32'(FAST_PEND_OFS), data);
    check_equal("fast_pend", data, 32'h0);
    wait_intr(32'hffff_ffff, 32'h0, "all lines low");
    end_test("fast_irq");
  endtask

  initial begin
    int cycles;
    seed        = 32'hb5b9_cb19;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    tests_run   = 0;
    bus_req     = '0;
    fast_intr   = '0;
    irq_ext     = 1'b0;
    cycles      = 0;
    while (!rst_n && cycles <= 100) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      errors++;
    end
    @(posedge clk);
    reset_state_test();
    ram_bank_test();
    unmapped_test();
    exit_reg_test();
    sw_ext_irq_test();
    fast_irq_test();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/mcu_pkg.sv
design/sys_bus_decoder.sv
design/ram_bank.sv
design/ao_peripheral_regs.sv
design/sys_bus_resp_mux.sv
design/mini_mcu_top.sv
testbench/mini_mcu_properties.sv
testbench/tb_clock_gen.sv
testbench/tb_mini_mcu.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and scan the log for the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_mini_mcu \
  -Mdir obj_dir -o tb_mini_mcu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mini_mcu > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation finished cleanly"
exit 0
